//--- vlog.f
hdl/uart_test_pkg.sv
hdl/uart_byte_if.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/loop_test_ctrl.sv
hdl/uart_loop_top.sv
tb/tb_clock.sv
tb/tb_uart_loop.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_uart_loop -o sim_uart_loop

out=$(./obj_dir/sim_uart_loop)
echo "$out"

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

//--- tb/tb_uart_loop.sv
module tb_uart_loop;
    import uart_test_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int ECHO_TIMEOUT = 200;
    localparam int GAP_CLKS     = 20;
    localparam int DRIVE_DELAY  = 10;
    localparam int FRAME_CLKS   = FRAME_BITS * CLKS_PER_BIT;

    logic       clk;
    logic       rst_n;
    logic       run;
    logic       rx;
    logic       tx;
    logic       active;
    logic       pass;
    logic       fail;
    logic [7:0] match_count;
    logic       loopback;
    logic       line_drive;

    integer     seed;
    int         errors;
    int         tests_run;
    int         tests_failed;
    logic [7:0] expected_count;

    // in loopback the receiver hears the DUT's own line, otherwise the testbench line.
    assign rx = loopback ? tx : line_drive;

    tb_clock #(
        .PERIOD       (100),
        .RESET_CYCLES (4)
    ) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    uart_loop_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .ECHO_TIMEOUT (ECHO_TIMEOUT),
        .GAP_CLKS     (GAP_CLKS)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .rx          (rx),
        .tx          (tx),
        .active      (active),
        .pass        (pass),
        .fail        (fail),
        .match_count (match_count)
    );

    // ################################################
    // reporting and basic stepping
    // ################################################

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        $display("Mismatch at time %0t: %s expected 0x%02h, got 0x%02h",
                 $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at time %0t: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic step_past_edge();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_idle_outputs();
        if (tx !== 1'b1) report_mismatch("tx", 8'd1, tx);
        if (active !== 1'b0) report_mismatch("active", 8'd0, active);
        if (pass !== 1'b0) report_mismatch("pass", 8'd0, pass);
        if (fail !== 1'b0) report_mismatch("fail", 8'd0, fail);
        if (match_count !== 8'd0) report_mismatch("match_count", 8'd0, match_count);
    endtask

    task automatic check_status(input logic exp_pass, input logic exp_fail);
        if (pass !== exp_pass) report_mismatch("pass", exp_pass, pass);
        if (fail !== exp_fail) report_mismatch("fail", exp_fail, fail);
        if (match_count !== expected_count) begin
            report_mismatch("match_count", expected_count, match_count);
        end
    endtask

    // ################################################
    // serial line helpers
    // ################################################

    // decodes one frame from the DUT's tx, sampling each bit near its middle.
    task automatic watch_frame(input int max_wait, output bit found, output logic [7:0] data,
                               output logic parity_bit, output logic stop_bit);
        int waited;
        waited     = 0;
        found      = 1'b0;
        data       = 8'h00;
        parity_bit = 1'b0;
        stop_bit   = 1'b0;
        @(negedge clk);
        while (tx !== 1'b0 && waited < max_wait) begin
            @(negedge clk);
            waited++;
        end
        if (tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
            found = (tx === 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            parity_bit = tx;
            repeat (CLKS_PER_BIT) @(negedge clk);
            stop_bit = tx;
            // return just after the stop bit has ended.
            repeat (CLKS_PER_BIT / 2 + 1) @(negedge clk);
        end
    endtask

    task automatic check_frame(input logic [7:0] expected, input int max_wait);
        bit         found;
        logic [7:0] data;
        logic       parity_bit;
        logic       stop_bit;
        watch_frame(max_wait, found, data, parity_bit, stop_bit);
        if (!found) begin
            report_failure("no valid start bit seen on tx");
        end else begin
            if (data !== expected) report_mismatch("tx frame data", expected, data);
            if (parity_bit !== ^data) report_mismatch("tx frame parity", ^data, parity_bit);
            if (stop_bit !== 1'b1) report_failure("stop bit of the tx frame was low");
        end
    endtask

    // drives one frame on the testbench line, optionally with inverted parity.
    task automatic send_frame(input logic [7:0] data, input bit bad_parity);
        logic [FRAME_BITS-1:0] bits;
        bits = {1'b1, (^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            step_past_edge();
            line_drive = bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic wait_active_low(input int max_wait, output int elapsed);
        elapsed = 0;
        while (active !== 1'b0 && elapsed < max_wait) begin
            @(negedge clk);
            elapsed++;
        end
        if (active !== 1'b0) report_failure("timed out waiting for active to fall");
    endtask

    // ################################################
    // directed tests
    // ################################################

    task automatic test_reset_state();
        int errors_before;
        int waited;
        errors_before = errors;
        @(posedge clk);
        @(negedge clk);
        if (rst_n !== 1'b0) report_failure("reset was not asserted at the first check");
        check_idle_outputs();
        waited = 0;
        while (rst_n !== 1'b1 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) report_failure("reset was never released");
        @(negedge clk);
        check_idle_outputs();
        finish_test("reset_state", errors_before);
    endtask

    task automatic test_good_loopback();
        logic [7:0] order [3];
        int         errors_before;
        int         elapsed;
        errors_before = errors;
        order[0] = CMD_TURN_ON;
        order[1] = CMD_TURN_OFF;
        order[2] = CMD_TOGGLE;
        step_past_edge();
        loopback = 1'b1;
        run      = 1'b1;
        for (int k = 0; k < 3; k++) begin
            check_frame(order[k], 4 * FRAME_CLKS);
            wait_active_low(4 * CLKS_PER_BIT, elapsed);
            expected_count = expected_count + 8'd1;
            check_status(1'b1, 1'b0);
        end
        finish_test("good_loopback", errors_before);
    endtask

    task automatic test_wrong_echo();
        logic [7:0] reply;
        integer     rnd;
        int         errors_before;
        int         elapsed;
        errors_before = errors;
        step_past_edge();
        loopback = 1'b0;
        check_frame(CMD_TURN_ON, 4 * FRAME_CLKS);
        rnd   = $random(seed);
        reply = rnd[7:0];
        // flipping one bit keeps a random hit on the expected byte wrong.
        if (reply == CMD_TURN_ON) reply = reply ^ 8'h01;
        send_frame(reply, 1'b0);
        wait_active_low(2 * CLKS_PER_BIT, elapsed);
        check_status(1'b0, 1'b1);
        finish_test("wrong_echo", errors_before);
    endtask

    task automatic test_parity_error();
        int errors_before;
        int elapsed;
        errors_before = errors;
        check_frame(CMD_TURN_OFF, 4 * FRAME_CLKS);
        send_frame(CMD_TURN_OFF, 1'b1);
        wait_active_low(2 * CLKS_PER_BIT, elapsed);
        check_status(1'b0, 1'b1);
        finish_test("parity_error", errors_before);
    endtask

    task automatic test_missing_echo();
        int errors_before;
        int elapsed;
        errors_before = errors;
        check_frame(CMD_TOGGLE, 4 * FRAME_CLKS);
        wait_active_low(ECHO_TIMEOUT + GAP_CLKS + 4 * CLKS_PER_BIT, elapsed);
        if (elapsed < ECHO_TIMEOUT - CLKS_PER_BIT) begin
            report_failure("exchange ended before the echo timeout ran out");
        end
        check_status(1'b0, 1'b1);
        // the cycle wraps around to the first command.
        check_frame(CMD_TURN_ON, 4 * FRAME_CLKS);
        finish_test("missing_echo", errors_before);
    endtask

    task automatic test_stopping();
        int errors_before;
        int elapsed;
        bit line_moved;
        bit active_seen;
        errors_before = errors;
        line_moved    = 1'b0;
        active_seen   = 1'b0;
        step_past_edge();
        run = 1'b0;
        wait_active_low(ECHO_TIMEOUT + GAP_CLKS + 4 * CLKS_PER_BIT, elapsed);
        repeat (6 * GAP_CLKS) begin
            @(negedge clk);
            if (tx !== 1'b1) line_moved = 1'b1;
            if (active !== 1'b0) active_seen = 1'b1;
        end
        if (line_moved) report_failure("tx left the idle level after run went low");
        if (active_seen) report_failure("a new exchange started after run went low");
        finish_test("stopping", errors_before);
    endtask

    initial begin
        run            = 1'b0;
        loopback       = 1'b1;
        line_drive     = 1'b1;
        seed           = 32'h3e69_c1eb;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        expected_count = 8'd0;

        test_reset_state();
        test_good_loopback();
        test_wrong_echo();
        test_parity_error();
        test_missing_echo();
        test_stopping();

        $display("summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset is released a little after a rising edge, like all other stimulus.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

//--- hdl/uart_loop_top.sv
module uart_loop_top #(
    parameter int CLKS_PER_BIT = 417,
    parameter int ECHO_TIMEOUT = 48000,
    parameter int GAP_CLKS     = 24000000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       rx,
    output logic       tx,
    output logic       active,
    output logic       pass,
    output logic       fail,
    output logic [7:0] match_count
);

    // ################################################
    // byte-level link between controller and engines
    // ################################################

    uart_byte_if bus_if ();

    loop_test_ctrl #(
        .ECHO_TIMEOUT (ECHO_TIMEOUT),
        .GAP_CLKS     (GAP_CLKS)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .bus         (bus_if.ctrl),
        .active      (active),
        .pass        (pass),
        .fail        (fail),
        .match_count (match_count)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus_if.tx),
        .tx    (tx)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .bus   (bus_if.rx)
    );

endmodule

//--- hdl/loop_test_ctrl.sv
module loop_test_ctrl #(
    parameter int ECHO_TIMEOUT = 48000,
    parameter int GAP_CLKS     = 24000000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run,
    uart_byte_if.ctrl   bus,
    output logic        active,
    output logic        pass,
    output logic        fail,
    output logic [7:0]  match_count
);
    import uart_test_pkg::*;

    localparam int CNT_MAX = (ECHO_TIMEOUT > GAP_CLKS) ? ECHO_TIMEOUT : GAP_CLKS;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam logic [CNT_W-1:0] TIMEOUT_LAST = CNT_W'(ECHO_TIMEOUT - 1);
    localparam logic [CNT_W-1:0] GAP_LAST     = CNT_W'(GAP_CLKS - 1);

    ctrl_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic [1:0]       cmd_idx;
    cmd_opcode_e      next_cmd;
    cmd_opcode_e      expected;
    logic             busy_q;
    logic             tx_fall;
    logic             echo_pend;
    logic             echo_pend_ok;
    logic             rx_match;
    logic             echo_valid;
    logic             echo_good;

    always_comb begin
        case (cmd_idx)
            2'd1:    next_cmd = CMD_TURN_OFF;
            2'd2:    next_cmd = CMD_TOGGLE;
            default: next_cmd = CMD_TURN_ON;
        endcase
    end

    // the transmitter takes the byte on the tx_start cycle, when expected is already loaded.
    assign bus.tx_data = expected;
    assign tx_fall     = busy_q && !bus.tx_busy;
    assign rx_match    = bus.rx_done && !bus.parity_error && (bus.rx_data == expected);
    assign echo_valid  = echo_pend || bus.rx_done;
    assign echo_good   = echo_pend ? echo_pend_ok : rx_match;
    assign active      = (state == ST_SEND) || (state == ST_WAIT_ECHO);

    // ################################################
    // exchange sequencing
    // ################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            cnt          <= '0;
            cmd_idx      <= 2'd0;
            expected     <= CMD_TURN_ON;
            bus.tx_start <= 1'b0;
            busy_q       <= 1'b0;
            echo_pend    <= 1'b0;
            echo_pend_ok <= 1'b0;
            pass         <= 1'b0;
            fail         <= 1'b0;
            match_count  <= 8'd0;
        end else begin
            bus.tx_start <= 1'b0;
            busy_q       <= bus.tx_busy;

            case (state)
                ST_IDLE: begin
                    if (run) begin
                        state        <= ST_SEND;
                        bus.tx_start <= 1'b1;
                        expected     <= next_cmd;
                    end
                end

                ST_SEND: begin
                    // on a direct loopback the stop bit is sampled before busy drops,
                    // so the echo is held until the wait state resolves it.
                    if (bus.rx_done && !echo_pend) begin
                        echo_pend    <= 1'b1;
                        echo_pend_ok <= rx_match;
                    end
                    if (tx_fall) begin
                        state <= ST_WAIT_ECHO;
                        cnt   <= '0;
                    end
                end

                ST_WAIT_ECHO: begin
                    if (echo_valid || cnt == TIMEOUT_LAST) begin
                        state     <= ST_GAP;
                        cnt       <= '0;
                        echo_pend <= 1'b0;
                        cmd_idx   <= (cmd_idx == 2'd2) ? 2'd0 : cmd_idx + 2'd1;
                        if (echo_valid && echo_good) begin
                            pass        <= 1'b1;
                            fail        <= 1'b0;
                            match_count <= match_count + 8'd1;
                        end else begin
                            pass <= 1'b0;
                            fail <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                ST_GAP: begin
                    if (cnt == GAP_LAST) begin
                        cnt <= '0;
                        if (run) begin
                            state        <= ST_SEND;
                            bus.tx_start <= 1'b1;
                            expected     <= next_cmd;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    pass_fail_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(pass && fail)
    );

endmodule

//--- hdl/uart_rx.sv
module uart_rx #(
    parameter int CLKS_PER_BIT = 417
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rx,
    uart_byte_if.rx  bus
);
    import uart_test_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_BITS,
        RX_STOP
    } rx_state_e;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(FRAME_BITS);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(CLKS_PER_BIT - 1);
    // data bits and the parity bit are counted, start and stop are not.
    localparam logic [IDX_W-1:0] PARITY_IDX = IDX_W'(FRAME_BITS - 3);
    localparam logic [IDX_W-1:0] DATA_END   = IDX_W'(DATA_BITS);

    rx_state_e            state;
    logic                 rx_s1;
    logic                 rx_s2;
    logic                 rx_prev;
    logic [CNT_W-1:0]     clk_cnt;
    logic [IDX_W-1:0]     bit_cnt;
    logic                 parity_acc;
    logic [DATA_BITS-1:0] data_sr;
    logic                 bit_tick;

    assign bit_tick = (clk_cnt == FULL_LAST);

    // ################################################
    // frame detection and sampling
    // ################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_s1            <= 1'b1;
            rx_s2            <= 1'b1;
            rx_prev          <= 1'b1;
            state            <= RX_IDLE;
            clk_cnt          <= '0;
            bit_cnt          <= '0;
            parity_acc       <= 1'b0;
            bus.rx_done      <= 1'b0;
            bus.parity_error <= 1'b0;
        end else begin
            rx_s1       <= rx;
            rx_s2       <= rx_s1;
            rx_prev     <= rx_s2;
            bus.rx_done <= 1'b0;

            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_s2) begin
                        state   <= RX_START;
                        clk_cnt <= '0;
                    end
                end

                RX_START: begin
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        // a line that is high again by mid start bit was only a glitch.
                        if (!rx_s2) begin
                            state      <= RX_BITS;
                            bit_cnt    <= '0;
                            parity_acc <= 1'b0;
                        end else begin
                            state <= RX_IDLE;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                RX_BITS: begin
                    if (bit_tick) begin
                        clk_cnt    <= '0;
                        parity_acc <= parity_acc ^ rx_s2;
                        if (bit_cnt == PARITY_IDX) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                RX_STOP: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        state   <= RX_IDLE;
                        // with even parity the running xor over data and parity is zero.
                        if (rx_s2) begin
                            bus.rx_done      <= 1'b1;
                            bus.parity_error <= parity_acc;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                default: state <= RX_IDLE;
            endcase
        end
    end

    // data arrives LSB first and is shifted in from the top.
    always_ff @(posedge clk) begin
        if (state == RX_BITS && bit_tick && bit_cnt < DATA_END) begin
            data_sr <= {rx_s2, data_sr[DATA_BITS-1:1]};
        end
        if (state == RX_STOP && bit_tick && rx_s2) begin
            bus.rx_data <= data_sr;
        end
    end

    single_cycle_done: assert property (
        @(posedge clk) disable iff (!rst_n) bus.rx_done |=> !bus.rx_done
    );

endmodule

//--- hdl/uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 417
) (
    input  logic     clk,
    input  logic     rst_n,
    uart_byte_if.tx  bus,
    output logic     tx
);
    import uart_test_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(FRAME_BITS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(FRAME_BITS - 1);

    // bits still to go after the start bit, LSB leaves first.
    logic [FRAME_BITS-2:0] frame_sr;
    logic [CNT_W-1:0]      clk_cnt;
    logic [IDX_W-1:0]      bit_idx;
    logic                  accept;
    logic                  bit_end;

    assign accept  = !bus.tx_busy && bus.tx_start;
    assign bit_end = bus.tx_busy && (clk_cnt == CNT_LAST);

    // ################################################
    // frame sequencing
    // ################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.tx_busy <= 1'b0;
            tx          <= 1'b1;
            clk_cnt     <= '0;
            bit_idx     <= '0;
        end else if (accept) begin
            // the start bit goes out on the cycle after the request.
            bus.tx_busy <= 1'b1;
            tx          <= 1'b0;
            clk_cnt     <= '0;
            bit_idx     <= '0;
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == IDX_LAST) begin
                bus.tx_busy <= 1'b0;
                tx          <= 1'b1;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                tx      <= frame_sr[0];
            end
        end else if (bus.tx_busy) begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // stop bit, even parity and data, loaded when the byte is accepted.
    always_ff @(posedge clk) begin
        if (accept) begin
            frame_sr <= {1'b1, ^bus.tx_data, bus.tx_data};
        end else if (bit_end) begin
            frame_sr <= {1'b1, frame_sr[FRAME_BITS-2:1]};
        end
    end

    // ################################################
    // checks
    // ################################################

    idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n) !bus.tx_busy |-> tx
    );

    // the controller must never request a byte while a frame is on the line.
    no_start_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) bus.tx_busy |-> !bus.tx_start
    );

endmodule

//--- hdl/uart_byte_if.sv
interface uart_byte_if;
    import uart_test_pkg::*;

    // transmit side, one byte per tx_start pulse.
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_start;
    logic                 tx_busy;

    // receive side, rx_data and parity_error are valid with rx_done.
    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_done;
    logic                 parity_error;

    modport ctrl (
        output tx_data, tx_start,
        input  tx_busy, rx_data, rx_done, parity_error
    );

    modport tx (
        input  tx_data, tx_start,
        output tx_busy
    );

    modport rx (
        output rx_data, rx_done, parity_error
    );

endinterface

//--- hdl/uart_test_pkg.sv
package uart_test_pkg;

    // ################################################
    // serial frame layout
    // ################################################

    // width of one data byte.
    localparam int DATA_BITS = 8;

    // start bit, eight data bits, even parity bit and one stop bit.
    localparam int FRAME_BITS = 11;

    // ################################################
    // command bytes and control states
    // ################################################

    // the declaration order is also the order in which the bytes are sent.
    typedef enum logic [DATA_BITS-1:0] {
        CMD_TURN_ON  = 8'hEE,
        CMD_TURN_OFF = 8'h55,
        CMD_TOGGLE   = 8'hC3
    } cmd_opcode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT_ECHO,
        ST_GAP
    } ctrl_state_e;

endpackage
